// File: hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int data_w = 8;
  localparam int pc_w   = 4;

  typedef logic [data_w-1:0] data_t;
  typedef logic [pc_w-1:0]   pc_t;

  ////////////////////
  // instruction set
  ////////////////////

  // upper nibble of an instruction word, codes c..f run as nop
  typedef enum logic [3:0] {
    OP_NOP    = 4'h0,
    OP_LDA_LO = 4'h1,
    OP_LDA_HI = 4'h2,
    OP_LDB_LO = 4'h3,
    OP_LDB_HI = 4'h4,
    OP_LDC_LO = 4'h5,
    OP_LDC_HI = 4'h6,
    OP_ADD    = 4'h7,
    OP_SUB    = 4'h8,
    OP_MUL    = 4'h9,
    OP_OUT    = 4'hA,
    OP_IN     = 4'hB
  } opcode_t;

  typedef enum logic [1:0] {REG_A = 2'd0, REG_B = 2'd1, REG_C = 2'd2} reg_sel_t;

  typedef enum logic [1:0] {WR_LO = 2'd0, WR_HI = 2'd1, WR_FULL = 2'd2} wr_part_t;

  typedef enum logic [1:0] {ALU_ADD = 2'd0, ALU_SUB = 2'd1, ALU_MUL = 2'd2} alu_op_t;

endpackage

`default_nettype wire

// File: hw/host_pins_pkg.sv
`default_nettype none

package host_pins_pkg;

  ////////////////////
  // uio_in fields
  ////////////////////

  // bit 7 is the run level
  localparam int run_bit = 7;

  // load field sits on bits 5:4
  localparam int load_lsb = 4;

  // field value that asks for a program write
  localparam logic [1:0] load_code = 2'b01;

  // program address on bits 3:0
  localparam int addr_lsb = 0;

endpackage

`default_nettype wire

// File: hw/reg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_if;
  import cpu_isa_pkg::*;

  // write request, taken at the rising edge where wr_en is high
  logic     wr_en;
  reg_sel_t wr_sel;
  wr_part_t wr_part;
  data_t    wr_data;

  // current register contents
  data_t a_val;
  data_t b_val;
  data_t c_val;

  modport ctrl (
    output wr_en, wr_sel, wr_part, wr_data,
    input  a_val, b_val, c_val
  );

  modport regs (
    input  wr_en, wr_sel, wr_part, wr_data,
    output a_val, b_val, c_val
  );

endinterface

`default_nettype wire

// File: hw/program_ram.sv
`timescale 1ns/1ps
`default_nettype none

module program_ram #(
  parameter int depth = 16
) (
  input  wire               clk,
  input  wire               reset,
  input  wire               wr_en,
  input  cpu_isa_pkg::pc_t   wr_addr,
  input  cpu_isa_pkg::data_t wr_data,
  input  cpu_isa_pkg::pc_t   rd_addr,
  output cpu_isa_pkg::data_t rd_data
);
  import cpu_isa_pkg::*;

  data_t mem [depth];

  // reset fills the store with nop words
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // fetch reads the old word when the host writes the same address
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter int depth = 16
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 run,
  output cpu_isa_pkg::pc_t     rd_addr,
  input  cpu_isa_pkg::data_t   rd_data,
  output logic                instr_valid,
  output cpu_isa_pkg::opcode_t opcode,
  output logic [3:0]          operand
);
  import cpu_isa_pkg::*;

  pc_t   pc;
  data_t ir;

  ////////////////////
  // program counter
  ////////////////////

  // advances only on edges where run is high, wraps at the last word
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (run) begin
      if (pc == pc_t'(depth - 1)) begin
        pc <= '0;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  assign rd_addr = pc;

  ////////////////////
  // instruction register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= run;
    end
  end

  // word holds while run is low, instr_valid says whether it still counts
  always_ff @(posedge clk) begin
    if (run) begin
      ir <= rd_data;
    end
  end

  // unused codes c..f fall back to nop
  always_comb begin
    if (ir[7:4] <= OP_IN) begin
      opcode = opcode_t'(ir[7:4]);
    end else begin
      opcode = OP_NOP;
    end
  end

  assign operand = ir[3:0];

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_isa_pkg::data_t   a,
  input  cpu_isa_pkg::data_t   b,
  input  cpu_isa_pkg::alu_op_t op,
  output cpu_isa_pkg::data_t   result
);
  import cpu_isa_pkg::*;

  // full product, only the low byte is kept
  logic [2*data_w-1:0] product;

  assign product = a * b;

  // all results wrap modulo 256
  always_comb begin
    case (op)
      ALU_SUB: result = a - b;
      ALU_MUL: result = product[data_w-1:0];
      default: result = a + b;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input wire clk,
  input wire reset,
  reg_if.regs regs
);
  import cpu_isa_pkg::*;

  localparam int nib_w = data_w / 2;

  // entry 0 is A, 1 is B, 2 is C
  data_t regs_q [3];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 3; i++) begin
        regs_q[i] <= '0;
      end
    end else if (regs.wr_en) begin
      case (regs.wr_part)
        // nibble loads leave the other half untouched
        WR_LO: begin
          regs_q[regs.wr_sel][nib_w-1:0] <= regs.wr_data[nib_w-1:0];
        end
        WR_HI: begin
          regs_q[regs.wr_sel][data_w-1:nib_w] <= regs.wr_data[data_w-1:nib_w];
        end
        default: begin
          regs_q[regs.wr_sel] <= regs.wr_data;
        end
      endcase
    end
  end

  ////////////////////
  // read side
  ////////////////////

  assign regs.a_val = regs_q[REG_A];
  assign regs.b_val = regs_q[REG_B];
  assign regs.c_val = regs_q[REG_C];

endmodule

`default_nettype wire

// File: hw/exec_control.sv
`timescale 1ns/1ps
`default_nettype none

module exec_control (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 instr_valid,
  input  cpu_isa_pkg::opcode_t opcode,
  input  wire [3:0]           operand,
  input  cpu_isa_pkg::data_t   ui_in,
  output cpu_isa_pkg::alu_op_t alu_op,
  input  cpu_isa_pkg::data_t   alu_result,
  reg_if.ctrl                 regs,
  output cpu_isa_pkg::data_t   uo_out
);
  import cpu_isa_pkg::*;

  logic       sel_ok;
  reg_sel_t   sel;
  logic [3:0] ld_idx;
  data_t      out_val;

  // IN and OUT name a register in the operand, 3 and above do nothing
  assign sel_ok = (operand <= 4'd2);
  assign sel    = reg_sel_t'(operand[1:0]);

  // load opcodes run 1..6 as A lo, A hi, B lo, B hi, C lo, C hi
  assign ld_idx = opcode - OP_LDA_LO;

  always_comb begin
    case (opcode)
      OP_SUB:  alu_op = ALU_SUB;
      OP_MUL:  alu_op = ALU_MUL;
      default: alu_op = ALU_ADD;
    endcase
  end

  ////////////////////
  // register write
  ////////////////////

  always_comb begin
    regs.wr_en   = 1'b0;
    regs.wr_sel  = REG_A;
    regs.wr_part = WR_FULL;
    regs.wr_data = ui_in;
    if (instr_valid) begin
      case (opcode)
        OP_LDA_LO, OP_LDA_HI, OP_LDB_LO, OP_LDB_HI, OP_LDC_LO, OP_LDC_HI: begin
          regs.wr_en   = 1'b1;
          regs.wr_sel  = reg_sel_t'(ld_idx[2:1]);
          regs.wr_part = ld_idx[0] ? WR_HI : WR_LO;
          // operand on both nibbles, reg_file picks the half it needs
          regs.wr_data = {operand, operand};
        end
        OP_ADD, OP_SUB, OP_MUL: begin
          regs.wr_en   = 1'b1;
          regs.wr_sel  = REG_C;
          regs.wr_data = alu_result;
        end
        OP_IN: begin
          regs.wr_en  = sel_ok;
          regs.wr_sel = sel;
        end
        default: begin
          regs.wr_en = 1'b0;
        end
      endcase
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_comb begin
    case (sel)
      REG_A:   out_val = regs.a_val;
      REG_B:   out_val = regs.b_val;
      default: out_val = regs.c_val;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      uo_out <= '0;
    end else if (instr_valid && opcode == OP_OUT && sel_ok) begin
      uo_out <= out_val;
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire               clk,
  input  wire               reset,
  input  cpu_isa_pkg::data_t ui_in,
  input  cpu_isa_pkg::data_t uio_in,
  output cpu_isa_pkg::data_t uo_out
);
  import cpu_isa_pkg::*;
  import host_pins_pkg::*;

  localparam int depth = 16;

  logic       run;
  logic       load_en;
  pc_t        load_addr;
  pc_t        rd_addr;
  data_t      rd_data;
  logic       instr_valid;
  opcode_t    opcode;
  logic [3:0] operand;
  alu_op_t    alu_op;
  data_t      alu_result;

  ////////////////////
  // host control decode
  ////////////////////

  assign run       = uio_in[run_bit];
  assign load_en   = (uio_in[load_lsb +: $bits(load_code)] == load_code);
  assign load_addr = uio_in[addr_lsb +: pc_w];

  reg_if regs_if ();

  ////////////////////
  // datapath
  ////////////////////

  program_ram #(.depth(depth)) ram_i (
    .clk(clk), .reset(reset),
    .wr_en(load_en), .wr_addr(load_addr), .wr_data(ui_in),
    .rd_addr(rd_addr), .rd_data(rd_data)
  );

  fetch_unit #(.depth(depth)) fetch_i (
    .clk(clk), .reset(reset), .run(run),
    .rd_addr(rd_addr), .rd_data(rd_data),
    .instr_valid(instr_valid), .opcode(opcode), .operand(operand)
  );

  exec_control exec_i (
    .clk(clk), .reset(reset),
    .instr_valid(instr_valid), .opcode(opcode), .operand(operand),
    .ui_in(ui_in), .alu_op(alu_op), .alu_result(alu_result),
    .regs(regs_if.ctrl), .uo_out(uo_out)
  );

  // ALU always works on A and B, exec_control decides where the result goes
  alu alu_i (
    .a(regs_if.a_val), .b(regs_if.b_val), .op(alu_op), .result(alu_result)
  );

  reg_file regs_i (
    .clk(clk), .reset(reset), .regs(regs_if.regs)
  );

endmodule

`default_nettype wire

// File: tb/cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
  input wire                  clk,
  input wire                  reset,
  input wire                  instr_valid,
  input cpu_isa_pkg::opcode_t opcode,
  input wire                  wr_en,
  input cpu_isa_pkg::data_t   a_val,
  input cpu_isa_pkg::data_t   b_val,
  input cpu_isa_pkg::data_t   c_val,
  input cpu_isa_pkg::data_t   uo_out
);
  import cpu_isa_pkg::*;

  int failures = 0;

  ////////////////////
  // output register
  ////////////////////

  // uo_out only moves on the edge that executes an OUT, or under reset
  out_after_out: assert property (
    @(posedge clk) disable iff (reset)
    !$stable(uo_out) |-> $past(reset) || $past(instr_valid && opcode == OP_OUT)
  ) else begin
    $error("uo_out changed without a valid OUT before it");
    failures++;
  end

  // first edge out of reset still sees a cleared output
  out_clear: assert property (
    @(posedge clk) $fell(reset) |-> uo_out == '0
  ) else begin
    $error("uo_out not zero after reset");
    failures++;
  end

  ////////////////////
  // register writes
  ////////////////////

  // registers only move after a valid write strobe or under reset
  reg_after_write: assert property (
    @(posedge clk) disable iff (reset)
    !$stable({a_val, b_val, c_val}) |-> $past(reset) || $past(wr_en && instr_valid)
  ) else begin
    $error("register changed without a valid write before it");
    failures++;
  end

endmodule

`default_nettype wire

// File: tb/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
  import cpu_isa_pkg::*;
  import host_pins_pkg::*;

  localparam int n_cases    = 7;
  localparam int prog_len   = 16;
  localparam int no_pause   = prog_len;
  localparam int edge_limit = 4;

  typedef struct {
    data_t   a;
    data_t   b;
    opcode_t op;
    data_t   in_val;
    bit      in_rand;
    int      pause_at;
    int      pause_len;
    data_t   exp_c;
  } case_t;

  logic  clk = 1'b0;
  logic  reset;
  data_t ui_in;
  data_t uio_in;
  data_t uo_out;

  case_t  cases [n_cases];
  data_t  prog [prog_len];
  data_t  exp_out [prog_len];
  int     errors;
  int     timeouts;
  integer seed;

  cpu_top dut_i (
    .clk(clk), .reset(reset), .ui_in(ui_in), .uio_in(uio_in), .uo_out(uo_out)
  );

  bind exec_control cpu_assertions asrt_i (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .opcode(opcode),
    .wr_en(regs.wr_en), .a_val(regs.a_val), .b_val(regs.b_val),
    .c_val(regs.c_val), .uo_out(uo_out)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic data_t instr_word(opcode_t op, logic [3:0] operand);
    return {op, operand};
  endfunction

  function automatic data_t load_ctrl(pc_t addr);
    data_t v;
    v = '0;
    v[load_lsb +: 2] = load_code;
    v[addr_lsb +: pc_w] = addr;
    return v;
  endfunction

  function automatic data_t run_ctrl();
    data_t v;
    v = '0;
    v[run_bit] = 1'b1;
    return v;
  endfunction

  // returns right after the next falling clock edge
  task automatic next_fall();
    int hops;
    hops = 0;
    do begin
      @(clk);
      hops++;
    end while (clk !== 1'b0 && hops < edge_limit);
    if (clk !== 1'b0) begin
      timeouts++;
      $display("timeout: clock did not fall within %0d transitions", edge_limit);
    end
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // case steps
  ////////////////////

  task automatic apply_reset();
    int waited;
    waited = 0;
    reset  = 1'b1;
    ui_in  = '0;
    uio_in = '0;
    repeat (8) next_fall();
    reset = 1'b0;
    next_fall();
    while (uo_out !== '0 && waited < 4) begin
      next_fall();
      waited++;
    end
    if (uo_out !== '0) begin
      timeouts++;
      $display("timeout: uo_out did not clear after reset");
    end
  endtask

  task automatic build_program(input case_t c, input data_t in_v);
    prog[0]  = instr_word(OP_OUT, 4'd0);
    prog[1]  = instr_word(OP_OUT, 4'd1);
    prog[2]  = instr_word(OP_OUT, 4'd2);
    prog[3]  = instr_word(OP_LDA_LO, c.a[3:0]);
    prog[4]  = instr_word(OP_LDA_HI, c.a[7:4]);
    prog[5]  = instr_word(OP_LDB_LO, c.b[3:0]);
    prog[6]  = instr_word(OP_LDB_HI, c.b[7:4]);
    prog[7]  = instr_word(OP_OUT, 4'd0);
    prog[8]  = instr_word(OP_OUT, 4'd1);
    prog[9]  = instr_word(c.op, 4'd0);
    prog[10] = instr_word(OP_OUT, 4'd2);
    prog[11] = instr_word(OP_IN, 4'd1);
    // unused codes, must act as nop
    prog[12] = 8'hC1;
    prog[13] = 8'hF1;
    prog[14] = instr_word(OP_OUT, 4'd1);
    prog[15] = instr_word(OP_OUT, 4'd2);
    // uo_out after each word has executed
    for (int i = 0; i < 7; i++) begin
      exp_out[i] = '0;
    end
    exp_out[7] = c.a;
    exp_out[8] = c.b;
    exp_out[9] = c.b;
    for (int i = 10; i < 14; i++) begin
      exp_out[i] = c.exp_c;
    end
    exp_out[14] = in_v;
    exp_out[15] = c.exp_c;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      uio_in = load_ctrl(pc_t'(i));
      ui_in  = prog[i];
      next_fall();
    end
    uio_in = '0;
  endtask

  // word k executes on the edge after the one that fetched it
  task automatic run_program(input case_t c);
    uio_in = run_ctrl();
    next_fall();
    check_value("uo_out", uo_out, '0);
    for (int k = 0; k < prog_len; k++) begin
      if (k == prog_len - 1 || k == c.pause_at) begin
        uio_in = '0;
      end else begin
        uio_in = run_ctrl();
      end
      next_fall();
      check_value("uo_out", uo_out, exp_out[k]);
      if (k == c.pause_at) begin
        for (int held = 1; held < c.pause_len; held++) begin
          next_fall();
          check_value("uo_out", uo_out, exp_out[k]);
          check_value("pc", data_t'(dut_i.fetch_i.pc), data_t'((k + 1) % prog_len));
        end
        if (k < prog_len - 1) begin
          // first edge back only fetches
          uio_in = run_ctrl();
          next_fall();
          check_value("uo_out", uo_out, exp_out[k]);
        end
      end
    end
  endtask

  // a, b, alu opcode, ui_in for IN, random ui_in, pause index, pause edges, expected C
  task automatic fill_table();
    cases[0] = '{8'h12, 8'h34, OP_ADD, 8'h5A, 1'b0, no_pause, 0, 8'h46};
    cases[1] = '{8'hC8, 8'h64, OP_ADD, 8'h00, 1'b1, 8, 4, 8'h2C};
    cases[2] = '{8'h30, 8'h45, OP_SUB, 8'hA5, 1'b0, no_pause, 0, 8'hEB};
    cases[3] = '{8'hFF, 8'h01, OP_SUB, 8'h00, 1'b1, 10, 3, 8'hFE};
    cases[4] = '{8'h0D, 8'h0B, OP_MUL, 8'h00, 1'b0, no_pause, 0, 8'h8F};
    cases[5] = '{8'hF0, 8'h11, OP_MUL, 8'h00, 1'b1, 14, 5, 8'hF0};
    cases[6] = '{8'h00, 8'h00, OP_ADD, 8'hFF, 1'b0, 0, 2, 8'h00};
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    data_t in_v;
    int    asrt_fails;
    reset    = 1'b1;
    ui_in    = '0;
    uio_in   = '0;
    errors   = 0;
    timeouts = 0;
    seed     = 32'hba58_53b7;
    fill_table();
    for (int n = 0; n < n_cases && timeouts == 0; n++) begin
      if (cases[n].in_rand) begin
        in_v = data_t'($random(seed));
      end else begin
        in_v = cases[n].in_val;
      end
      build_program(cases[n], in_v);
      apply_reset();
      load_program();
      ui_in = in_v;
      run_program(cases[n]);
    end
    asrt_fails = dut_i.exec_i.asrt_i.failures;
    $display("mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, asrt_fails);
    if (errors == 0 && timeouts == 0 && asrt_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hw/cpu_isa_pkg.sv
hw/host_pins_pkg.sv
hw/reg_if.sv
hw/program_ram.sv
hw/fetch_unit.sv
hw/alu.sv
hw/reg_file.sv
hw/exec_control.sv
hw/cpu_top.sv
tb/cpu_assertions.sv
tb/tb_cpu.sv

// File: Makefile
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f verilog.f

run: obj_dir/Vtb_cpu
	-./obj_dir/Vtb_cpu +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	grep -qx 'NO ERRORS' sim.log

clean:
	rm -rf obj_dir sim.log
